// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tile_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+include
logic/cgra_tile_pkg.sv
logic/cgra_mem_pkg.sv
logic/issue_stage.sv
logic/tile_alu.sv
logic/load_store_unit.sv
logic/writeback_stage.sv
logic/tile_core.sv
verification/tile_tb.sv

// ==== logic/cgra_mem_pkg.sv ====
`default_nettype none

package cgra_mem_pkg;

    localparam int MEM_ADDR_W = 9;
    localparam int MEM_DATA_W = 32;
    localparam int MEM_BE_W   = MEM_DATA_W / 8;

    // lane patterns at offset zero, shifted up by the byte offset
    localparam logic [MEM_BE_W-1:0] BE_NONE = 4'b0000;
    localparam logic [MEM_BE_W-1:0] BE_WORD = 4'b1111;
    localparam logic [MEM_BE_W-1:0] BE_HALF = 4'b0011;
    localparam logic [MEM_BE_W-1:0] BE_BYTE = 4'b0001;

    typedef enum logic [1:0] {
        WORD = 2'd0,
        HALF = 2'd1,
        BYTE = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_BE_W-1:0]   be;
        logic [MEM_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/cgra_tile_pkg.sv ====
`default_nettype none

package cgra_tile_pkg;

    localparam int DATA_W = 32;
    localparam int LOOP_W = 5;

    // neighbour and result flit, valid bit on top
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } flit_t;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, SELECT,
        LOAD_W, LOAD_H, LOAD_B,
        STORE_W, STORE_H, STORE_B,
        SET_LOOP, NOP
    } opcode_e;

    // codes 5 and 6 select an invalid zero flit
    typedef enum logic [2:0] {
        SRC_NORTH  = 3'd0,
        SRC_EAST   = 3'd1,
        SRC_SOUTH  = 3'd2,
        SRC_WEST   = 3'd3,
        SRC_TREG   = 3'd4,
        SRC_UNUSED = 3'd7
    } src_e;

    // ----------------------------------------
    // 64-bit control word, two views
    // ----------------------------------------
    typedef struct packed {
        logic [30:0] reserved;
        logic [15:0] constant;
        logic        pred_inv;
        logic        const_flag;
        opcode_e     opcode;
        logic        treg_we;
        src_e        pred_src;
        src_e        lhs_src;
        src_e        rhs_src;
    } ctrl_alu_t;

    typedef struct packed {
        logic [36:0]       reserved;
        logic [LOOP_W-1:0] loop_end;
        logic [LOOP_W-1:0] loop_start;
        logic              pred_inv;
        logic              const_flag;
        opcode_e           opcode;
        logic              treg_we;
        src_e              pred_src;
        src_e              lhs_src;
        src_e              rhs_src;
    } ctrl_loop_t;

    typedef union packed {
        ctrl_alu_t  alu;
        ctrl_loop_t loop;
    } ctrl_word_u;

    // item in flight between the stages
    typedef struct packed {
        logic              valid;
        logic              fire;
        opcode_e           opcode;
        flit_t             rhs;
        flit_t             lhs;
        logic              use_const;
        logic [DATA_W-1:0] constant;
        logic              treg_we;
    } exec_t;

endpackage

`default_nettype wire

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import cgra_tile_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              i_start_exec,
    input  ctrl_word_u        i_ctrl,
    input  flit_t [3:0]       i_flit_in,
    input  flit_t             i_treg,
    output exec_t             o_exec,
    output logic [LOOP_W-1:0] o_loop_start,
    output logic [LOOP_W-1:0] o_loop_end
);

    ctrl_alu_t ctl;
    flit_t     rhs;
    flit_t     lhs;
    flit_t     pred;
    logic      rhs_ok;
    logic      lhs_ok;
    logic      pred_ok;
    logic      sel_ok;
    logic      fire_now;
    exec_t     exec_next;

    // neighbours 0 to 3, tile register 4, anything else an invalid zero flit
    function automatic flit_t pick_operand(src_e src, flit_t [3:0] flits, flit_t treg);
        case (src)
            SRC_NORTH, SRC_EAST, SRC_SOUTH, SRC_WEST: return flits[src[1:0]];
            SRC_TREG: return treg;
            default: return '0;
        endcase
    endfunction

    assign ctl  = i_ctrl.alu;
    assign rhs  = pick_operand(ctl.rhs_src, i_flit_in, i_treg);
    assign lhs  = pick_operand(ctl.lhs_src, i_flit_in, i_treg);
    assign pred = pick_operand(ctl.pred_src, i_flit_in, i_treg);

    // ----------------------------------------
    // firing rule
    // ----------------------------------------
    assign rhs_ok  = (ctl.rhs_src == SRC_UNUSED) || rhs.valid;
    assign lhs_ok  = ctl.const_flag || (ctl.lhs_src == SRC_UNUSED) || lhs.valid;
    assign pred_ok = (ctl.pred_src == SRC_UNUSED)
                     || (pred.valid && ((|pred.data) ^ ctl.pred_inv));
    // select only needs one side
    assign sel_ok  = rhs.valid || lhs.valid || ctl.const_flag;

    assign fire_now = i_start_exec && pred_ok
                      && ((ctl.opcode == SELECT) ? sel_ok : (rhs_ok && lhs_ok));

    always_comb
    begin
        exec_next.valid     = 1'b1;
        exec_next.fire      = fire_now;
        exec_next.opcode    = ctl.opcode;
        exec_next.rhs       = rhs;
        exec_next.lhs       = lhs;
        exec_next.use_const = ctl.const_flag;
        exec_next.constant  = {{(DATA_W-16){ctl.constant[15]}}, ctl.constant};
        exec_next.treg_we   = ctl.treg_we;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            o_exec <= '0;
        else if (i_start_exec)
            o_exec <= exec_next;
        else
        begin
            o_exec.valid <= 1'b0;
            o_exec.fire  <= 1'b0;
        end
    end

    // loop bounds load regardless of the firing rule
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_loop_start <= '0;
            o_loop_end   <= '0;
        end
        else if (i_start_exec && i_ctrl.loop.opcode == SET_LOOP)
        begin
            o_loop_start <= i_ctrl.loop.loop_start;
            o_loop_end   <= i_ctrl.loop.loop_end;
        end
    end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import cgra_tile_pkg::*, cgra_mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  exec_t             i_exec,
    input  logic [DATA_W-1:0] i_mem_rdata,
    output mem_req_t          o_mem_req,
    output logic [DATA_W-1:0] o_load_data
);

    logic                  is_load;
    logic                  is_store;
    mem_size_e             size;
    logic [MEM_ADDR_W+1:0] byte_addr;
    logic [1:0]            offset;
    logic [MEM_BE_W-1:0]   be;
    logic [DATA_W-1:0]     lane_data;
    logic                  access;

    mem_size_e         ld_size_q;
    logic [1:0]        ld_off_q;
    mem_size_e         ld_size_d;
    logic [1:0]        ld_off_d;
    logic              ld_act_d;
    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] load_val;

    assign is_load  = i_exec.opcode inside {LOAD_W, LOAD_H, LOAD_B};
    assign is_store = i_exec.opcode inside {STORE_W, STORE_H, STORE_B};

    always_comb
    begin
        case (i_exec.opcode)
            LOAD_H, STORE_H: size = HALF;
            LOAD_B, STORE_B: size = BYTE;
            default:         size = WORD;
        endcase
    end

    // ----------------------------------------
    // request build
    // ----------------------------------------
    assign byte_addr = i_exec.use_const ? i_exec.constant[MEM_ADDR_W+1:0]
                                        : i_exec.lhs.data[MEM_ADDR_W+1:0];
    assign offset    = byte_addr[1:0];

    always_comb
    begin
        case (size)
            // odd half-word offset gets no lanes
            HALF:    be = offset[0] ? BE_NONE : BE_HALF << offset;
            BYTE:    be = BE_BYTE << offset;
            default: be = BE_WORD;
        endcase
        case (size)
            HALF:    lane_data = {16'h0000, i_exec.rhs.data[15:0]} << {offset, 3'b000};
            BYTE:    lane_data = {24'h000000, i_exec.rhs.data[7:0]} << {offset, 3'b000};
            default: lane_data = i_exec.rhs.data;
        endcase
    end

    assign access = i_exec.valid && i_exec.fire && (is_load || is_store) && (be != BE_NONE);

    always_ff @(posedge clk)
    begin
        if (reset)
            o_mem_req <= '0;
        else
        begin
            o_mem_req.read  <= access && is_load;
            o_mem_req.write <= access && is_store;
            o_mem_req.addr  <= byte_addr[MEM_ADDR_W+1:2];
            o_mem_req.be    <= be;
            o_mem_req.wdata <= lane_data;
        end
    end

    // size and offset follow the read to the returning data
    always_ff @(posedge clk)
    begin
        ld_size_q <= size;
        ld_off_q  <= offset;
        ld_size_d <= ld_size_q;
        ld_off_d  <= ld_off_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ld_act_d <= 1'b0;
        else
            ld_act_d <= o_mem_req.read;
    end

    // ----------------------------------------
    // load extraction, zero extended
    // ----------------------------------------
    assign shifted = i_mem_rdata >> {ld_off_d, 3'b000};

    always_comb
    begin
        case (ld_size_d)
            HALF:    load_val = {16'h0000, shifted[15:0]};
            BYTE:    load_val = {24'h000000, shifted[7:0]};
            default: load_val = i_mem_rdata;
        endcase
    end

    assign o_load_data = ld_act_d ? load_val : '0;

endmodule

`default_nettype wire

// ==== logic/tile_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_alu
    import cgra_tile_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  exec_t             i_exec,
    output logic [DATA_W-1:0] o_alu_result,
    output exec_t             o_exec_d
);

    logic [DATA_W-1:0] lhs_op;
    logic [DATA_W-1:0] rhs_op;
    logic [4:0]        shamt;
    logic [DATA_W-1:0] result;

    // constant stands in for the left operand
    assign lhs_op = i_exec.use_const ? i_exec.constant : i_exec.lhs.data;
    assign rhs_op = i_exec.rhs.data;
    assign shamt  = rhs_op[4:0];

    always_comb
    begin
        case (i_exec.opcode)
            ADD:     result = lhs_op + rhs_op;
            SUB:     result = lhs_op - rhs_op;
            AND:     result = lhs_op & rhs_op;
            OR:      result = lhs_op | rhs_op;
            XOR:     result = lhs_op ^ rhs_op;
            SHL:     result = lhs_op << shamt;
            SHR:     result = lhs_op >> shamt;
            // rhs wins when both sides are valid
            SELECT:  result = i_exec.rhs.valid ? rhs_op : lhs_op;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        o_alu_result <= result;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            o_exec_d <= '0;
        else
            o_exec_d <= i_exec;
    end

endmodule

`default_nettype wire

// ==== logic/tile_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_core
    import cgra_tile_pkg::*, cgra_mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              i_start_exec,
    input  ctrl_word_u        i_ctrl,
    input  flit_t [3:0]       i_flit_in,
    input  logic [DATA_W-1:0] i_mem_rdata,
    output flit_t             o_result,
    output mem_req_t          o_mem_req,
    output logic [LOOP_W-1:0] o_loop_start,
    output logic [LOOP_W-1:0] o_loop_end
);

    exec_t             exec;
    exec_t             exec_d;
    flit_t             treg;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] load_data;

    issue_stage u_issue (
        .clk          (clk),
        .reset        (reset),
        .i_start_exec (i_start_exec),
        .i_ctrl       (i_ctrl),
        .i_flit_in    (i_flit_in),
        .i_treg       (treg),
        .o_exec       (exec),
        .o_loop_start (o_loop_start),
        .o_loop_end   (o_loop_end)
    );

    tile_alu u_alu (
        .clk          (clk),
        .reset        (reset),
        .i_exec       (exec),
        .o_alu_result (alu_result),
        .o_exec_d     (exec_d)
    );

    load_store_unit u_lsu (
        .clk         (clk),
        .reset       (reset),
        .i_exec      (exec),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_req   (o_mem_req),
        .o_load_data (load_data)
    );

    writeback_stage u_wb (
        .clk          (clk),
        .reset        (reset),
        .i_exec_d     (exec_d),
        .i_alu_result (alu_result),
        .i_load_data  (load_data),
        .o_result     (o_result),
        .o_treg       (treg)
    );

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import cgra_tile_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  exec_t             i_exec_d,
    input  logic [DATA_W-1:0] i_alu_result,
    input  logic [DATA_W-1:0] i_load_data,
    output flit_t             o_result,
    output flit_t             o_treg
);

    exec_t             exec_q;
    logic [DATA_W-1:0] alu_q;
    logic              is_load;
    flit_t             result_next;

    // one more stage so the ALU result lines up with the load data
    always_ff @(posedge clk)
    begin
        if (reset)
            exec_q <= '0;
        else
            exec_q <= i_exec_d;
    end

    always_ff @(posedge clk)
    begin
        alu_q <= i_alu_result;
    end

    assign is_load = exec_q.opcode inside {LOAD_W, LOAD_H, LOAD_B};

    always_comb
    begin
        result_next.valid = exec_q.fire;
        if (!exec_q.fire)
            result_next.data = '0;
        else if (is_load)
            result_next.data = i_load_data;
        else
            result_next.data = alu_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_result <= '0;
            o_treg   <= '0;
        end
        else
        begin
            o_result <= result_next;
            // tile register takes the same flit, fired or not
            if (exec_q.valid && exec_q.treg_we)
                o_treg <= result_next;
        end
    end

endmodule

`default_nettype wire

// ==== include/tile_model.svh ====
`ifndef TILE_MODEL_SVH
`define TILE_MODEL_SVH

// expected ALU data, constant sign extended into the left operand
function automatic logic [DATA_W-1:0] model_alu(ctrl_alu_t ctl, flit_t rhs, flit_t lhs);
    logic [DATA_W-1:0] a;
    a = ctl.const_flag ? {{16{ctl.constant[15]}}, ctl.constant} : lhs.data;
    case (ctl.opcode)
        ADD:     return a + rhs.data;
        SUB:     return a - rhs.data;
        AND:     return a & rhs.data;
        OR:      return a | rhs.data;
        XOR:     return a ^ rhs.data;
        SHL:     return a << rhs.data[4:0];
        SHR:     return a >> rhs.data[4:0];
        SELECT:  return rhs.valid ? rhs.data : a;
        default: return '0;
    endcase
endfunction

// unused sources pass, predicate truth flips with invert
function automatic logic model_fire(ctrl_alu_t ctl, flit_t rhs, flit_t lhs, flit_t pred);
    logic r_ok;
    logic l_ok;
    logic p_ok;
    r_ok = (ctl.rhs_src == SRC_UNUSED) || rhs.valid;
    l_ok = ctl.const_flag || (ctl.lhs_src == SRC_UNUSED) || lhs.valid;
    p_ok = (ctl.pred_src == SRC_UNUSED) || (pred.valid && ((pred.data != 0) != ctl.pred_inv));
    if (ctl.opcode == SELECT)
        return p_ok && (rhs.valid || lhs.valid || ctl.const_flag);
    return p_ok && r_ok && l_ok;
endfunction

function automatic logic [3:0] model_store_be(mem_size_e size, logic [1:0] off);
    case (size)
        HALF:    return (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
        BYTE:    return 4'b0001 << off;
        default: return 4'b1111;
    endcase
endfunction

function automatic logic [31:0] model_store_data(mem_size_e size, logic [1:0] off,
                                                 logic [31:0] rhs);
    case (size)
        HALF:    return off[1] ? {rhs[15:0], 16'h0000} : {16'h0000, rhs[15:0]};
        BYTE:    return {24'h000000, rhs[7:0]} << (8 * off);
        default: return rhs;
    endcase
endfunction

// misaligned half-words read nothing
function automatic logic [31:0] model_load(mem_size_e size, logic [1:0] off,
                                           logic [31:0] word);
    case (size)
        HALF:    return off[0] ? 32'h0 : {16'h0000, word[16*off[1] +: 16]};
        BYTE:    return {24'h000000, word[8*off +: 8]};
        default: return word;
    endcase
endfunction

`endif

// ==== verification/tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_tb
    import cgra_tile_pkg::*, cgra_mem_pkg::*;
();

    localparam int DRAIN_LIMIT = 50;
    localparam int RUN_LIMIT   = 2000;
    localparam int MEM_WORDS   = 1 << MEM_ADDR_W;

    typedef flit_t [3:0] flits_t;

    // expected result flit and the cycle count at which it shows
    typedef struct packed {
        logic [31:0] due;
        flit_t       flit;
        logic        treg_we;
    } exp_res_t;

    typedef struct packed {
        logic [31:0] due;
        mem_req_t    req;
    } exp_mem_t;

    logic              clk;
    logic              reset;
    logic              i_start_exec;
    ctrl_word_u        i_ctrl;
    flits_t            i_flit_in;
    logic [DATA_W-1:0] i_mem_rdata;
    flit_t             o_result;
    mem_req_t          o_mem_req;
    logic [LOOP_W-1:0] o_loop_start;
    logic [LOOP_W-1:0] o_loop_end;

    logic [31:0] mem     [0:MEM_WORDS-1];
    logic [31:0] ref_mem [0:MEM_WORDS-1];
    mem_req_t    req_seen;
    flit_t       model_treg;
    exp_res_t    res_q[$];
    exp_mem_t    mem_q[$];
    int          cyc;
    int          checks;
    int          errors;
    bit          checking;
    bit          stim_done;
    bit          timed_out;

    `include "tile_model.svh"

    tile_core uut (
        .clk          (clk),
        .reset        (reset),
        .i_start_exec (i_start_exec),
        .i_ctrl       (i_ctrl),
        .i_flit_in    (i_flit_in),
        .i_mem_rdata  (i_mem_rdata),
        .o_result     (o_result),
        .o_mem_req    (o_mem_req),
        .o_loop_start (o_loop_start),
        .o_loop_end   (o_loop_end)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] fill_word(int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ (idx << 23);
    endfunction

    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] wdata,
                                                logic [3:0] be);
        logic [31:0] word;
        int          b;
        word = old;
        for (b = 0; b < 4; b++)
            if (be[b])
                word[8*b +: 8] = wdata[8*b +: 8];
        return word;
    endfunction

    function automatic flit_t pick_flit(src_e src, flits_t f);
        if (src < 4)
            return f[src[1:0]];
        if (src == SRC_TREG)
            return model_treg;
        return '0;
    endfunction

    function automatic mem_size_e op_size(opcode_e op);
        case (op)
            LOAD_H, STORE_H: return HALF;
            LOAD_B, STORE_B: return BYTE;
            default:         return WORD;
        endcase
    endfunction

    // tile register excluded since back-to-back items see a stale copy
    function automatic src_e rand_src();
        logic [2:0] code;
        code = 3'($urandom_range(7, 0));
        if (code == 3'd4)
            code = 3'd7;
        return src_e'(code);
    endfunction

    function automatic flits_t rand_flits(bit mixed);
        flits_t f;
        int     j;
        for (j = 0; j < 4; j++)
        begin
            f[j].valid = mixed ? 1'($urandom_range(1, 0)) : 1'b1;
            f[j].data  = (mixed && $urandom_range(3, 0) == 0) ? '0 : $urandom;
        end
        return f;
    endfunction

    function automatic ctrl_word_u make_ctrl(opcode_e op, src_e rs, src_e ls, src_e ps,
                                             logic inv, logic we);
        ctrl_word_u c;
        c = '0;
        c.alu.opcode   = op;
        c.alu.rhs_src  = rs;
        c.alu.lhs_src  = ls;
        c.alu.pred_src = ps;
        c.alu.pred_inv = inv;
        c.alu.treg_we  = we;
        return c;
    endfunction

    task automatic log_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        i_start_exec = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((res_q.size() > 0 || mem_q.size() > 0) && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (res_q.size() > 0 || mem_q.size() > 0)
        begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: expected results still pending after %0d cycles", DRAIN_LIMIT);
        end
    endtask

    // ----------------------------------------
    // stimulus and expected values
    // ----------------------------------------
    // start sampled at the next edge, request two edges on, result four
    task automatic issue_item(ctrl_word_u c, flits_t f);
        ctrl_alu_t   ctl;
        flit_t       rhs;
        flit_t       lhs;
        flit_t       pred;
        logic        fire;
        logic        is_ld;
        logic        is_st;
        mem_size_e   sz;
        logic [10:0] baddr;
        exp_res_t    r;
        exp_mem_t    m;
        @(posedge clk);
        #1;
        i_ctrl       = c;
        i_flit_in    = f;
        i_start_exec = 1'b1;
        ctl   = c.alu;
        rhs   = pick_flit(ctl.rhs_src, f);
        lhs   = pick_flit(ctl.lhs_src, f);
        pred  = pick_flit(ctl.pred_src, f);
        fire  = model_fire(ctl, rhs, lhs, pred);
        is_ld = ctl.opcode inside {LOAD_W, LOAD_H, LOAD_B};
        is_st = ctl.opcode inside {STORE_W, STORE_H, STORE_B};
        sz    = op_size(ctl.opcode);
        baddr = ctl.const_flag ? ctl.constant[10:0] : lhs.data[10:0];
        m     = '0;
        m.due = cyc + 2;
        if (fire && (is_ld || is_st) && model_store_be(sz, baddr[1:0]) != 4'b0000)
        begin
            m.req.read  = is_ld;
            m.req.write = is_st;
            m.req.addr  = baddr[10:2];
            m.req.be    = model_store_be(sz, baddr[1:0]);
            m.req.wdata = model_store_data(sz, baddr[1:0], rhs.data);
        end
        r.due        = cyc + 4;
        r.treg_we    = ctl.treg_we;
        r.flit.valid = fire;
        if (!fire)
            r.flit.data = '0;
        else if (is_ld)
            r.flit.data = model_load(sz, baddr[1:0], ref_mem[baddr[10:2]]);
        else
            r.flit.data = model_alu(ctl, rhs, lhs);
        if (m.req.write)
            ref_mem[m.req.addr] = merge_lanes(ref_mem[m.req.addr], m.req.wdata, m.req.be);
        res_q.push_back(r);
        mem_q.push_back(m);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        checks++;
        assert (o_result.valid == 1'b0)
            else log_mismatch("o_result.valid", o_result.valid, 0);
        assert (o_result.data == '0)
            else log_mismatch("o_result.data", o_result.data, 0);
        assert (o_mem_req.read == 1'b0)
            else log_mismatch("o_mem_req.read", o_mem_req.read, 0);
        assert (o_mem_req.write == 1'b0)
            else log_mismatch("o_mem_req.write", o_mem_req.write, 0);
        assert (o_loop_start == '0)
            else log_mismatch("o_loop_start", o_loop_start, 0);
        assert (o_loop_end == '0)
            else log_mismatch("o_loop_end", o_loop_end, 0);
    endtask

    task automatic run_alu_random(int count);
        ctrl_word_u c;
        int         n;
        for (n = 0; n < count; n++)
        begin
            c = make_ctrl(opcode_e'(5'($urandom_range(7, 0))),
                          src_e'(3'($urandom_range(3, 0))),
                          src_e'(3'($urandom_range(3, 0))), SRC_UNUSED, 1'b0, 1'b0);
            c.alu.const_flag = 1'($urandom_range(1, 0));
            c.alu.constant   = 16'($urandom);
            issue_item(c, rand_flits(1'b0));
        end
        go_idle();
    endtask

    // north 5, east invalid, south zero, west 7
    task automatic run_firing_directed();
        flits_t f;
        f[0] = '{valid: 1'b1, data: 32'd5};
        f[1] = '{valid: 1'b0, data: 32'd9};
        f[2] = '{valid: 1'b1, data: 32'd0};
        f[3] = '{valid: 1'b1, data: 32'd7};
        issue_item(make_ctrl(ADD, SRC_NORTH, SRC_EAST, SRC_UNUSED, 1'b0, 1'b0), f);
        issue_item(make_ctrl(ADD, SRC_NORTH, SRC_WEST, SRC_SOUTH, 1'b0, 1'b0), f);
        issue_item(make_ctrl(ADD, SRC_NORTH, SRC_WEST, SRC_WEST, 1'b1, 1'b0), f);
        issue_item(make_ctrl(ADD, SRC_NORTH, SRC_WEST, SRC_WEST, 1'b0, 1'b0), f);
        issue_item(make_ctrl(STORE_W, SRC_NORTH, SRC_WEST, SRC_SOUTH, 1'b0, 1'b0), f);
        issue_item(make_ctrl(LOAD_W, SRC_UNUSED, SRC_WEST, SRC_SOUTH, 1'b0, 1'b0), f);
        issue_item(make_ctrl(SELECT, SRC_EAST, SRC_NORTH, SRC_UNUSED, 1'b0, 1'b0), f);
        issue_item(make_ctrl(SELECT, SRC_NORTH, SRC_EAST, SRC_UNUSED, 1'b0, 1'b0), f);
        issue_item(make_ctrl(SELECT, SRC_EAST, src_e'(3'd5), SRC_UNUSED, 1'b0, 1'b0), f);
        go_idle();
    endtask

    task automatic run_firing_random(int count);
        ctrl_word_u c;
        int         n;
        for (n = 0; n < count; n++)
        begin
            c = make_ctrl(opcode_e'(5'($urandom_range(13, 0))), rand_src(), rand_src(),
                          rand_src(), 1'($urandom_range(1, 0)), 1'b0);
            c.alu.const_flag = 1'($urandom_range(1, 0));
            c.alu.constant   = 16'($urandom);
            issue_item(c, rand_flits(1'b1));
        end
        go_idle();
    endtask

    // small address window so loads meet earlier stores
    task automatic run_mem_random(int count);
        ctrl_word_u c;
        flits_t     f;
        opcode_e    op;
        int         n;
        for (n = 0; n < count; n++)
        begin
            op = opcode_e'(5'($urandom_range(13, 8)));
            c  = make_ctrl(op, (op < STORE_W) ? SRC_UNUSED : SRC_NORTH, SRC_WEST,
                           SRC_UNUSED, 1'b0, 1'b0);
            c.alu.const_flag = 1'($urandom_range(1, 0));
            c.alu.constant   = 16'($urandom_range(63, 0));
            f = rand_flits(1'b0);
            f[3].data[10:0] = 11'($urandom_range(63, 0));
            issue_item(c, f);
        end
        go_idle();
    endtask

    task automatic run_treg_reuse(int count);
        int n;
        for (n = 0; n < count; n++)
        begin
            issue_item(make_ctrl(ADD, SRC_NORTH, SRC_EAST, SRC_UNUSED, 1'b0, 1'b1),
                       rand_flits(1'b0));
            go_idle();
            wait_drain();
            issue_item(make_ctrl(XOR, SRC_TREG, SRC_SOUTH, SRC_UNUSED, 1'b0, 1'b0),
                       rand_flits(1'b0));
            go_idle();
            wait_drain();
            // xor had no write, so the add result is still there
            issue_item(make_ctrl(SELECT, SRC_TREG, SRC_WEST, SRC_UNUSED, 1'b0, 1'b0),
                       rand_flits(1'b0));
            go_idle();
            wait_drain();
        end
    endtask

    task automatic run_set_loop(int count);
        ctrl_word_u c;
        int         n;
        for (n = 0; n < count; n++)
        begin
            c = make_ctrl(SET_LOOP, SRC_UNUSED, SRC_UNUSED, SRC_UNUSED, 1'b0, 1'b0);
            c.loop.loop_start = 5'($urandom);
            c.loop.loop_end   = 5'($urandom);
            issue_item(c, rand_flits(1'b0));
            // bounds settle at the edge that samples the start
            go_idle();
            @(negedge clk);
            checks++;
            assert (o_loop_start == c.loop.loop_start)
                else log_mismatch("o_loop_start", o_loop_start, c.loop.loop_start);
            assert (o_loop_end == c.loop.loop_end)
                else log_mismatch("o_loop_end", o_loop_end, c.loop.loop_end);
        end
    endtask

    // ----------------------------------------
    // memory model, one cycle read latency
    // ----------------------------------------
    always @(negedge clk)
        req_seen = o_mem_req;

    always @(posedge clk)
    begin
        #1;
        if (req_seen.write)
            mem[req_seen.addr] = merge_lanes(mem[req_seen.addr], req_seen.wdata, req_seen.be);
        if (req_seen.read)
            i_mem_rdata = mem[req_seen.addr];
        else
            i_mem_rdata = $urandom;
    end

    // compare at the falling edge, away from the DUT's updates
    always @(negedge clk)
    begin : compare_outputs
        exp_res_t r;
        exp_mem_t m;
        if (checking)
        begin
            if (res_q.size() > 0 && res_q[0].due == cyc)
            begin
                r = res_q.pop_front();
                checks++;
                assert (o_result.valid == r.flit.valid)
                    else log_mismatch("o_result.valid", o_result.valid, r.flit.valid);
                assert (o_result.data == r.flit.data)
                    else log_mismatch("o_result.data", o_result.data, r.flit.data);
                if (r.treg_we)
                    model_treg = r.flit;
            end
            else
            begin
                assert (o_result.valid == 1'b0)
                    else log_mismatch("o_result.valid", o_result.valid, 0);
            end
            m = '0;
            if (mem_q.size() > 0 && mem_q[0].due == cyc)
            begin
                m = mem_q.pop_front();
                checks++;
            end
            assert (o_mem_req.read == m.req.read)
                else log_mismatch("o_mem_req.read", o_mem_req.read, m.req.read);
            assert (o_mem_req.write == m.req.write)
                else log_mismatch("o_mem_req.write", o_mem_req.write, m.req.write);
            if (m.req.read || m.req.write)
            begin
                assert (o_mem_req.addr == m.req.addr)
                    else log_mismatch("o_mem_req.addr", o_mem_req.addr, m.req.addr);
                assert (o_mem_req.be == m.req.be)
                    else log_mismatch("o_mem_req.be", o_mem_req.be, m.req.be);
            end
            if (m.req.write)
            begin
                assert (o_mem_req.wdata == m.req.wdata)
                    else log_mismatch("o_mem_req.wdata", o_mem_req.wdata, m.req.wdata);
            end
        end
    end

    // ----------------------------------------
    // end of run
    // ----------------------------------------
    initial
    begin : report
        int waited;
        waited = 0;
        while (!stim_done && !timed_out && waited < RUN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!stim_done && !timed_out)
        begin
            errors++;
            $display("timeout: stimulus still running after %0d cycles", RUN_LIMIT);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin : main
        int i;
        void'($urandom(32'hecb3_06ce));
        clk          = 1'b0;
        reset        = 1'b1;
        i_start_exec = 1'b0;
        i_ctrl       = '0;
        i_flit_in    = '0;
        i_mem_rdata  = '0;
        cyc          = 0;
        checks       = 0;
        errors       = 0;
        checking     = 1'b0;
        stim_done    = 1'b0;
        timed_out    = 1'b0;
        model_treg   = '0;
        for (i = 0; i < MEM_WORDS; i++)
        begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        checking = 1'b1;
        run_alu_random(40);
        run_firing_directed();
        run_firing_random(60);
        run_mem_random(60);
        wait_drain();
        run_treg_reuse(4);
        run_set_loop(3);
        wait_drain();
        stim_done = 1'b1;
    end

endmodule

`default_nettype wire
